// ==== logic/linear_pkg.sv ====
`default_nettype none

package linear_pkg;

  // Layer shape
  localparam int IN_FEATURES  = 4;
  localparam int OUT_FEATURES = 4;
  localparam int BATCH_ROWS   = 4;

  // Q3.4 for data, weights and bias
  localparam int DATA_W    = 8;
  localparam int DATA_FRAC = 4;

  // Q11.4 for products and results
  localparam int OUT_W    = 16;
  localparam int OUT_FRAC = 4;

  // Derived widths
  localparam int PROD_W     = 2 * DATA_W;
  localparam int SUM_W      = PROD_W + $clog2(IN_FEATURES);
  localparam int PROD_SHIFT = 2 * DATA_FRAC - OUT_FRAC;
  localparam int W_CNT_W    = $clog2(OUT_FEATURES);
  localparam int ROW_CNT_W  = $clog2(BATCH_ROWS);

  typedef logic signed [DATA_W-1:0] data_t;
  typedef logic signed [PROD_W-1:0] prod_t;
  typedef logic signed [OUT_W-1:0]  out_t;

  // One data row, or one weight row (element i is W[j][i])
  typedef struct packed {
    data_t [IN_FEATURES-1:0] elem;
  } in_vec_t;

  typedef struct packed {
    data_t [OUT_FEATURES-1:0] elem;
  } bias_vec_t;

  // Product vectors and final results
  typedef struct packed {
    out_t [OUT_FEATURES-1:0] elem;
  } out_vec_t;

endpackage

`default_nettype wire

// ==== logic/weight_matmul.sv ====
`default_nettype none

module weight_matmul
  import linear_pkg::*;
(
  input  logic     clk,
  input  logic     i_rst_n,
  input  in_vec_t  i_weight,
  input  logic     i_weight_valid,
  output logic     o_weight_ready,
  input  in_vec_t  i_data,
  input  logic     i_data_valid,
  output logic     o_data_ready,
  output out_vec_t o_prod,
  output logic     o_prod_valid,
  input  logic     i_prod_ready
);

  in_vec_t              w_store [OUT_FEATURES];
  logic [W_CNT_W-1:0]   w_cnt;
  logic                 w_full;
  logic                 w_full_d;
  logic [ROW_CNT_W-1:0] row_cnt;
  logic                 w_acc;
  logic                 d_acc;
  logic                 last_row;
  logic                 s1_valid;
  logic                 s1_adv;
  logic                 s2_free;
  prod_t                s1_prod [OUT_FEATURES][IN_FEATURES];
  out_vec_t             sum_d;

  assign w_acc    = i_weight_valid && o_weight_ready;
  assign s2_free  = !o_prod_valid || i_prod_ready;
  assign s1_adv   = !s1_valid || s2_free;
  // Data only flows once all weight rows are in
  assign o_data_ready = w_full && s1_adv;
  assign d_acc    = i_data_valid && o_data_ready;
  assign last_row = d_acc && (row_cnt == ROW_CNT_W'(BATCH_ROWS - 1));

  always_comb begin
    w_full_d = w_full;
    if (w_acc && (w_cnt == W_CNT_W'(OUT_FEATURES - 1))) begin
      w_full_d = 1'b1;
    end else if (last_row) begin
      // Store frees while the last rows drain
      w_full_d = 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      w_cnt          <= '0;
      w_full         <= 1'b0;
      o_weight_ready <= 1'b0;
      row_cnt        <= '0;
    end else begin
      w_full         <= w_full_d;
      o_weight_ready <= !w_full_d;
      if (w_acc) begin
        w_cnt <= (w_cnt == W_CNT_W'(OUT_FEATURES - 1)) ? '0 : w_cnt + 1'b1;
      end
      if (d_acc) begin
        row_cnt <= last_row ? '0 : row_cnt + 1'b1;
      end
    end
  end

  // Weight rows land in arrival order
  always_ff @(posedge clk) begin
    if (w_acc) begin
      w_store[w_cnt] <= i_weight;
    end
  end

  // Stage 1 registers all sixteen products
  always_ff @(posedge clk) begin
    if (d_acc) begin
      for (int j = 0; j < OUT_FEATURES; j++) begin
        for (int i = 0; i < IN_FEATURES; i++) begin
          s1_prod[j][i] <= i_data.elem[i] * w_store[j].elem[i];
        end
      end
    end
  end

  // Dot products back to the output format with floor rounding
  always_comb begin
    logic signed [SUM_W-1:0] acc;
    for (int j = 0; j < OUT_FEATURES; j++) begin
      acc = '0;
      for (int i = 0; i < IN_FEATURES; i++) begin
        acc = acc + s1_prod[j][i];
      end
      sum_d.elem[j] = OUT_W'(acc >>> PROD_SHIFT);
    end
  end

  // Stage 2 payload
  always_ff @(posedge clk) begin
    if (s2_free && s1_valid) begin
      o_prod <= sum_d;
    end
  end

  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      s1_valid     <= 1'b0;
      o_prod_valid <= 1'b0;
    end else begin
      if (s1_adv) begin
        s1_valid <= d_acc;
      end
      if (s2_free) begin
        o_prod_valid <= s1_valid;
      end
    end
  end

  // Store must have wrapped to a full set and the weight port be closed
  a_data_needs_full_store : assert property (
    @(posedge clk) disable iff (!i_rst_n)
    d_acc |-> (w_cnt == '0) && !o_weight_ready
  ) else $error("data row accepted with incomplete weight store");

endmodule

`default_nettype wire

// ==== logic/bias_repeat_buffer.sv ====
`default_nettype none

module bias_repeat_buffer
  import linear_pkg::*;
(
  input  logic      clk,
  input  logic      i_rst_n,
  input  bias_vec_t i_bias,
  input  logic      i_bias_valid,
  output logic      o_bias_ready,
  output bias_vec_t o_rep_bias,
  output logic      o_rep_bias_valid,
  input  logic      i_rep_bias_ready
);

  logic                 full;
  logic                 full_d;
  logic [ROW_CNT_W-1:0] rep_cnt;
  logic                 b_acc;
  logic                 r_acc;
  logic                 last_rep;

  assign b_acc    = i_bias_valid && o_bias_ready;
  assign r_acc    = full && i_rep_bias_ready;
  assign last_rep = r_acc && (rep_cnt == ROW_CNT_W'(BATCH_ROWS - 1));

  assign o_rep_bias_valid = full;

  always_comb begin
    full_d = full;
    if (b_acc) begin
      full_d = 1'b1;
    end else if (last_rep) begin
      full_d = 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      full         <= 1'b0;
      o_bias_ready <= 1'b0;
      rep_cnt      <= '0;
    end else begin
      full         <= full_d;
      // Open for a new bias as soon as the old one is used up
      o_bias_ready <= !full_d;
      if (r_acc) begin
        rep_cnt <= last_rep ? '0 : rep_cnt + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (b_acc) begin
      o_rep_bias <= i_bias;
    end
  end

  // Count stays in range and is back at zero whenever the buffer is empty
  a_rep_cnt_range : assert property (
    @(posedge clk) disable iff (!i_rst_n)
    (rep_cnt <= ROW_CNT_W'(BATCH_ROWS - 1)) && (full || (rep_cnt == '0))
  ) else $error("bias repeat counter out of range");

endmodule

`default_nettype wire

// ==== logic/bias_add_slice.sv ====
`default_nettype none

module bias_add_slice
  import linear_pkg::*;
(
  input  logic      clk,
  input  logic      i_rst_n,
  input  out_vec_t  i_prod,
  input  logic      i_prod_valid,
  output logic      o_prod_ready,
  input  bias_vec_t i_bias,
  input  logic      i_bias_valid,
  output logic      o_bias_ready,
  output out_vec_t  o_out,
  output logic      o_out_valid,
  input  logic      i_out_ready
);

  out_vec_t sum_d;
  out_vec_t skid_q;
  logic     skid_valid;
  logic     slice_ready;
  logic     join_fire;
  logic     main_free;

  // Join so both sides transfer on the same edge
  assign slice_ready  = !skid_valid;
  assign o_prod_ready = i_bias_valid && slice_ready;
  assign o_bias_ready = i_prod_valid && slice_ready;
  assign join_fire    = i_prod_valid && i_bias_valid && slice_ready;
  assign main_free    = !o_out_valid || i_out_ready;

  // Bias is already Q.4 so only the width grows
  always_comb begin
    out_t bias_ext;
    for (int j = 0; j < OUT_FEATURES; j++) begin
      bias_ext      = {{(OUT_W - DATA_W){i_bias.elem[j][DATA_W-1]}}, i_bias.elem[j]};
      sum_d.elem[j] = i_prod.elem[j] + bias_ext;
    end
  end

  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      o_out_valid <= 1'b0;
      skid_valid  <= 1'b0;
    end else if (main_free) begin
      // Skid entry goes first when present
      o_out_valid <= skid_valid || join_fire;
      skid_valid  <= 1'b0;
    end else if (join_fire) begin
      skid_valid <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (main_free) begin
      if (skid_valid) begin
        o_out <= skid_q;
      end else if (join_fire) begin
        o_out <= sum_d;
      end
    end else if (join_fire) begin
      skid_q <= sum_d;
    end
  end

  a_out_hold : assert property (
    @(posedge clk) disable iff (!i_rst_n)
    (o_out_valid && !i_out_ready) |=> o_out_valid && $stable(o_out)
  ) else $error("o_out changed while stalled");

endmodule

`default_nettype wire

// ==== logic/linear_layer_top.sv ====
`default_nettype none

module linear_layer_top
  import linear_pkg::*;
(
  input  logic      clk,
  input  logic      i_rst_n,
  input  in_vec_t   i_weight,
  input  logic      i_weight_valid,
  output logic      o_weight_ready,
  input  bias_vec_t i_bias,
  input  logic      i_bias_valid,
  output logic      o_bias_ready,
  input  in_vec_t   i_data,
  input  logic      i_data_valid,
  output logic      o_data_ready,
  output out_vec_t  o_out,
  output logic      o_out_valid,
  input  logic      i_out_ready
);

  // Product stream
  out_vec_t  prod;
  logic      prod_valid;
  logic      prod_ready;

  // Repeated bias stream
  bias_vec_t rep_bias;
  logic      rep_bias_valid;
  logic      rep_bias_ready;

  weight_matmul i_weight_matmul (
    .clk            (clk),
    .i_rst_n        (i_rst_n),
    .i_weight       (i_weight),
    .i_weight_valid (i_weight_valid),
    .o_weight_ready (o_weight_ready),
    .i_data         (i_data),
    .i_data_valid   (i_data_valid),
    .o_data_ready   (o_data_ready),
    .o_prod         (prod),
    .o_prod_valid   (prod_valid),
    .i_prod_ready   (prod_ready)
  );

  bias_repeat_buffer i_bias_repeat_buffer (
    .clk              (clk),
    .i_rst_n          (i_rst_n),
    .i_bias           (i_bias),
    .i_bias_valid     (i_bias_valid),
    .o_bias_ready     (o_bias_ready),
    .o_rep_bias       (rep_bias),
    .o_rep_bias_valid (rep_bias_valid),
    .i_rep_bias_ready (rep_bias_ready)
  );

  bias_add_slice i_bias_add_slice (
    .clk          (clk),
    .i_rst_n      (i_rst_n),
    .i_prod       (prod),
    .i_prod_valid (prod_valid),
    .o_prod_ready (prod_ready),
    .i_bias       (rep_bias),
    .i_bias_valid (rep_bias_valid),
    .o_bias_ready (rep_bias_ready),
    .o_out        (o_out),
    .o_out_valid  (o_out_valid),
    .i_out_ready  (i_out_ready)
  );

endmodule

`default_nettype wire

// ==== tb/linear_tb.sv ====
`default_nettype none

module linear_tb
  import linear_pkg::*;
();

  localparam int NUM_BATCHES = 5;
  localparam int NUM_FIXED   = 3;
  localparam int TIMEOUT     = 200;
  localparam int LATENCY     = 3;

  // One table entry per batch
  typedef struct packed {
    in_vec_t   [OUT_FEATURES-1:0] weight;
    bias_vec_t                    bias;
    in_vec_t   [BATCH_ROWS-1:0]   data;
    out_vec_t  [BATCH_ROWS-1:0]   result;
  } batch_t;

  logic      clk;
  logic      i_rst_n;
  in_vec_t   i_weight;
  logic      i_weight_valid;
  logic      o_weight_ready;
  bias_vec_t i_bias;
  logic      i_bias_valid;
  logic      o_bias_ready;
  in_vec_t   i_data;
  logic      i_data_valid;
  logic      o_data_ready;
  out_vec_t  o_out;
  logic      o_out_valid;
  logic      i_out_ready;

  batch_t batches [NUM_BATCHES];
  int     errors;
  int     timeouts;
  int     cyc;
  int     rows_sent;
  int     beats_seen;
  logic   stall_mode;
  int     accept_cyc [$];
  int     valid_cyc [$];

  linear_layer_top i_linear_layer_top (
    .clk            (clk),
    .i_rst_n        (i_rst_n),
    .i_weight       (i_weight),
    .i_weight_valid (i_weight_valid),
    .o_weight_ready (o_weight_ready),
    .i_bias         (i_bias),
    .i_bias_valid   (i_bias_valid),
    .o_bias_ready   (o_bias_ready),
    .i_data         (i_data),
    .i_data_valid   (i_data_valid),
    .o_data_ready   (o_data_ready),
    .o_out          (o_out),
    .o_out_valid    (o_out_valid),
    .i_out_ready    (i_out_ready)
  );

  initial clk = 1'b0;
  always #4 clk = ~clk;

  // Cycle count that is read only on the falling edge
  initial cyc = 0;
  always @(posedge clk) begin
    cyc <= cyc + 1;
  end

  task automatic check_value(input string name, input logic [63:0] exp_v,
                             input logic [63:0] act_v);
    if (act_v !== exp_v) begin
      errors++;
      $display("[ERROR] %s expected 0x%0h got 0x%0h at %0t", name, exp_v, act_v, $time);
    end
  endtask

  // y[j] = floor(sum x[i]*W[j][i] / 2^4) + b[j]
  function automatic out_vec_t expected_row(input batch_t bt, input int r);
    out_vec_t y;
    int       acc;
    for (int j = 0; j < OUT_FEATURES; j++) begin
      acc = 0;
      for (int i = 0; i < IN_FEATURES; i++) begin
        acc = acc + int'($signed(bt.data[r].elem[i])) * int'($signed(bt.weight[j].elem[i]));
      end
      acc = (acc >>> (2 * DATA_FRAC - OUT_FRAC)) + int'($signed(bt.bias.elem[j]));
      y.elem[j] = out_t'(acc);
    end
    return y;
  endfunction

  task automatic build_table();
    // Identity with two half-weight rows and zero bias to show floor on negatives
    batches[0].weight = {32'h0800_0000, 32'h0008_0000, 32'h0000_1000, 32'h0000_0010};
    batches[0].bias   = 32'h0000_0000;
    batches[0].data   = {32'hF980_FF00, 32'h017F_017F, 32'hFFFD_80F0, 32'h0706_2010};
    batches[0].result = {64'hFFFC_FFC0_FFFF_0000, 64'h0000_003F_0001_007F,
                         64'hFFFF_FFFE_FF80_FFF0, 64'h0003_0003_0020_0010};
    // Full identity with one bias for all rows
    batches[1].weight = {32'h1000_0000, 32'h0010_0000, 32'h0000_1000, 32'h0000_0010};
    batches[1].bias   = 32'h807F_F010;
    batches[1].data   = {32'h0000_0000, 32'h8080_8080, 32'h7F7F_7F7F, 32'h0403_0201};
    batches[1].result = {64'hFF80_007F_FFF0_0010, 64'hFF00_FFFF_FF70_FF90,
                         64'hFFFF_00FE_006F_008F, 64'hFF84_0082_FFF2_0011};
    // Mixing weights and a new bias
    batches[2].weight = {32'h0000_0020, 32'h0808_0808, 32'hF010_F010, 32'h1010_1010};
    batches[2].bias   = 32'h02FF_0001;
    batches[2].data   = {32'h8080_7F7F, 32'h0100_03F8, 32'hFB03_0201, 32'h1010_1010};
    batches[2].result = {64'h0100_FFFE_0000_FFFF, 64'hFFF2_FFFD_FFF4_FFFD,
                         64'h0004_FFFF_0007_0002, 64'h0022_001F_0000_0041};
    for (int b = NUM_FIXED; b < NUM_BATCHES; b++) begin
      for (int k = 0; k < OUT_FEATURES; k++) begin
        batches[b].weight[k] = $urandom;
      end
      batches[b].bias = $urandom;
      for (int r = 0; r < BATCH_ROWS; r++) begin
        batches[b].data[r] = $urandom;
      end
      for (int r = 0; r < BATCH_ROWS; r++) begin
        batches[b].result[r] = expected_row(batches[b], r);
      end
    end
  endtask

  function automatic logic ready_of(input int s);
    case (s)
      0:       return o_weight_ready;
      1:       return o_bias_ready;
      default: return o_data_ready;
    endcase
  endfunction

  // Returns on the falling edge before the transfer edge
  task automatic wait_ready(input int s, input string what);
    int n;
    n = 0;
    while (!ready_of(s) && n < TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    if (!ready_of(s)) begin
      timeouts++;
      $display("Timeout: the %s stream never became ready", what);
    end
  endtask

  task automatic wait_beats(input int n);
    int t;
    t = 0;
    while (beats_seen < n && t < TIMEOUT) begin
      @(negedge clk);
      t++;
    end
    if (beats_seen < n) begin
      timeouts++;
      $display("Timeout: result stream stalled after %0d of %0d beats", beats_seen, n);
    end
  endtask

  task automatic random_gap();
    if (stall_mode) begin
      repeat ($urandom_range(0, 2)) @(negedge clk);
    end
  endtask

  task automatic push_batch(input batch_t bt);
    for (int k = 0; k < OUT_FEATURES; k++) begin
      i_weight       = bt.weight[k];
      i_weight_valid = 1'b1;
      wait_ready(0, "weight");
      @(negedge clk);
      i_weight_valid = 1'b0;
      random_gap();
    end
    i_bias       = bt.bias;
    i_bias_valid = 1'b1;
    wait_ready(1, "bias");
    @(negedge clk);
    i_bias_valid = 1'b0;
    random_gap();
    for (int r = 0; r < BATCH_ROWS; r++) begin
      i_data       = bt.data[r];
      i_data_valid = 1'b1;
      wait_ready(2, "data");
      rows_sent++;
      if (!stall_mode) begin
        accept_cyc.push_back(cyc + 1);
      end
      @(negedge clk);
      i_data_valid = 1'b0;
      random_gap();
    end
  endtask

  // Monitor collects result beats in order and notes when each first shows valid
  initial begin : monitor
    logic pending;
    int   start;
    pending = 1'b0;
    start   = 0;
    forever begin
      @(negedge clk);
      i_out_ready = stall_mode ? ($urandom_range(0, 3) != 0) : 1'b1;
      if (o_out_valid) begin
        if (rows_sent == 0) begin
          errors++;
          $display("Result beat appeared before any data row was sent");
        end
        if (!pending) begin
          start = cyc + 1;
        end
        pending = 1'b1;
        if (i_out_ready) begin
          if (beats_seen < NUM_BATCHES * BATCH_ROWS) begin
            check_value("o_out", batches[beats_seen / BATCH_ROWS].result[beats_seen % BATCH_ROWS],
                        o_out);
            if (beats_seen < NUM_FIXED * BATCH_ROWS) begin
              valid_cyc.push_back(start);
            end
          end else begin
            errors++;
            $display("Extra result beat beyond the expected stream");
          end
          beats_seen++;
          pending = 1'b0;
        end
      end
    end
  end

  initial begin : driver
    void'($urandom(68));
    i_rst_n        = 1'b0;
    i_weight       = '0;
    i_weight_valid = 1'b0;
    i_bias         = '0;
    i_bias_valid   = 1'b0;
    i_data         = '0;
    i_data_valid   = 1'b0;
    i_out_ready    = 1'b1;
    errors         = 0;
    timeouts       = 0;
    rows_sent      = 0;
    beats_seen     = 0;
    stall_mode     = 1'b0;
    build_table();
    repeat (5) begin
      @(negedge clk);
      check_value("o_out_valid", 1'b0, o_out_valid);
      check_value("o_data_ready", 1'b0, o_data_ready);
      check_value("o_weight_ready", 1'b0, o_weight_ready);
      check_value("o_bias_ready", 1'b0, o_bias_ready);
    end
    i_rst_n = 1'b1;
    @(negedge clk);
    check_value("o_weight_ready", 1'b1, o_weight_ready);
    check_value("o_bias_ready", 1'b1, o_bias_ready);
    for (int b = 0; b < NUM_BATCHES; b++) begin
      if (b == NUM_FIXED) begin
        // Fixed batches fully drained before stalls begin
        wait_beats(NUM_FIXED * BATCH_ROWS);
        stall_mode = 1'b1;
      end
      push_batch(batches[b]);
    end
    wait_beats(NUM_BATCHES * BATCH_ROWS);
    repeat (20) @(negedge clk);
    check_value("result beat count", NUM_BATCHES * BATCH_ROWS, beats_seen);
    check_value("latency samples", accept_cyc.size(), valid_cyc.size());
    foreach (valid_cyc[k]) begin
      if (k < accept_cyc.size()) begin
        check_value("o_out_valid cycle", accept_cyc[k] + LATENCY, valid_cyc[k]);
      end
    end
    $display("Errors: %0d, timeouts: %0d", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog.f ====
logic/linear_pkg.sv
logic/weight_matmul.sv
logic/bias_repeat_buffer.sv
logic/bias_add_slice.sv
logic/linear_layer_top.sv
tb/linear_tb.sv

// ==== Bender.yml ====
package:
  name: linear_layer

sources:
  - logic/linear_pkg.sv
  - logic/weight_matmul.sv
  - logic/bias_repeat_buffer.sv
  - logic/bias_add_slice.sv
  - logic/linear_layer_top.sv
  - target: simulation
    files:
      - tb/linear_tb.sv
